// ==== build.f ====
hdl/fpnorm_pkg.sv
hdl/fp_normalize.sv
hdl/fp_round.sv
hdl/fpnorm_top.sv
tb/tb_clock.sv
tb/fpnorm_props.sv
tb/fpnorm_tb.sv

// ==== tb/fpnorm_tb.sv ====
/* Directed tests for the normalize-and-round pipeline. A scoreboard checks
   every result and its flags two cycles after the operation was issued. */
`timescale 1ns/100ps

module fpnorm_tb;

  logic                                   rst;
  logic                                   in_valid;
  logic [fpnorm_pkg::mant_in_w-1:0]       mant_in;
  logic signed [fpnorm_pkg::exp_in_w-1:0] exp_in;
  logic                                   sign_in;
  fpnorm_pkg::op_e                        op;
  fpnorm_pkg::fmt_e                       fmt;
  fpnorm_pkg::rm_e                        rm;
  logic                                   inf_a, inf_b, zero_a, zero_b;
  logic                                   nan_a, nan_b, snan;
  logic                                   clk, out_valid;
  logic [31:0]                            result;
  logic [fpnorm_pkg::fflags_w-1:0]        fflags;

  //////////////////////////////
  // Scoreboard
  //////////////////////////////
  logic [31:0] want_q[$];          // Expected results in issue order
  logic [4:0]  flags_q[$];         // {NV,DZ,OF,UF,NX}
  int          cycle_q[$];         // Issue cycle of each
  logic [31:0] want;
  logic [4:0]  want_flags;
  int          issue_cycle;
  int          cycle = 0;
  int          issued = 0;
  int          checks = 0;
  int          errors = 0;
  int          n_rand = 8;         // Random operations per mode
  integer      seed = 32'h716b;

  tb_clock tb_clock_i (.clk);

  fpnorm_top fpnorm_top_i
  (
    .clk, .rst, .in_valid, .mant_in, .exp_in, .sign_in, .op, .fmt, .rm,
    .inf_a, .inf_b, .zero_a, .zero_b, .nan_a, .nan_b, .snan,
    .out_valid, .result, .fflags
  );

  always @(posedge clk)
    cycle <= cycle + 1;

  // Round-up decision from guard, sticky and sign
  function automatic logic round_decision(input fpnorm_pkg::rm_e mode, input logic s,
                                          input logic g, input logic st, input logic lsb);
    case (mode)
      fpnorm_pkg::rm_rne: return g && (st || lsb);  // Half to even
      fpnorm_pkg::rm_rdn: return (g || st) && s;
      fpnorm_pkg::rm_rup: return (g || st) && !s;
      fpnorm_pkg::rm_rmm: return g;                 // Half away from zero
      default:            return 1'b0;              // Truncate
    endcase
  endfunction

  // Expected {NX, result} of a normal 1.xxx input
  function automatic logic [32:0] expect_normal(input logic [27:0] m, input int e,
                                                input logic s, input fpnorm_pkg::rm_e mode,
                                                input logic half);
    logic [23:0] kept;
    logic [24:0] sum;
    logic        g, st, carry;
    int          e_out;
    kept = half ? {13'd0, m[27:17]} : m[27:4];   // Hidden bit + fraction
    g    = half ? m[16] : m[3];
    st   = half ? |m[15:0] : |m[2:0];
    sum  = {1'b0, kept} + {24'd0, round_decision(mode, s, g, st, kept[0])};
    carry = half ? sum[11] : sum[24];
    e_out = carry ? e + 1 : e;
    if (carry)
      sum = '0;                                   // 1.111 + ulp is 10.000
    if (half)
      return {g | st, 16'hffff, s, 5'(e_out), sum[9:0]};
    return {g | st, s, 8'(e_out), sum[22:0]};
  endfunction

  // Drive one operation after the next edge and queue its expected response
  task automatic issue(input logic [27:0] m, input int e, input logic s,
                       input fpnorm_pkg::op_e o, input fpnorm_pkg::fmt_e f,
                       input fpnorm_pkg::rm_e mode, input logic [6:0] cls,
                       input logic [31:0] w, input logic [4:0] wf);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    mant_in  = m;
    exp_in   = 10'(e);
    sign_in  = s;
    op       = o;
    fmt      = f;
    rm       = mode;
    {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} = cls;
    want_q.push_back(w);
    flags_q.push_back(wf);
    cycle_q.push_back(cycle);
    issued++;
  endtask

  // Stop issuing, wait for outstanding results with a bound
  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    while (want_q.size() != 0 && waited < 8)
    begin
      @(posedge clk);
      waited++;
    end
    if (want_q.size() != 0)
    begin
      $display("Error: %0d results never left the pipeline", want_q.size());
      errors += want_q.size();
      want_q.delete();
      flags_q.delete();
      cycle_q.delete();
    end
  endtask

  // Compare at the falling edge, outputs settled
  always @(negedge clk)
  begin
    if (!rst && out_valid)
    begin
      if (want_q.size() == 0)
      begin
        $display("Error at %0t ns: out_valid with no operation outstanding", $time);
        errors++;
      end
      else
      begin
        want        = want_q.pop_front();
        want_flags  = flags_q.pop_front();
        issue_cycle = cycle_q.pop_front();
        checks++;
        if (cycle - issue_cycle != 2)
        begin
          $display("FAIL %0t ns: latency %0d cycles, expected 2", $time, cycle - issue_cycle);
          errors++;
        end
        if (result !== want)
        begin
          $display("FAIL %0t ns: result %h, expected %h", $time, result, want);
          errors++;
        end
        if (fflags !== want_flags)
        begin
          $display("FAIL %0t ns: fflags %b, expected %b", $time, fflags, want_flags);
          errors++;
        end
      end
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////
  // cls is {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b}
  task automatic test_special();
    logic [27:0] m;
    m = 28'h8000000;                                                 // 1.0
    issue(m, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32, fpnorm_pkg::rm_rne,
          7'b0000011, 32'h7fc00000, 5'b11000);                       // 0/0
    issue(m, 127, 1'b1, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32, fpnorm_pkg::rm_rne,
          7'b0000001, 32'hff800000, 5'b01000);                       // -x/0
    issue(m, 127, 1'b1, fpnorm_pkg::op_sqrt, fpnorm_pkg::fmt_fp32, fpnorm_pkg::rm_rne,
          7'b0000001, 32'h7fc00000, 5'b10000);                       // sqrt(-x), zero_b ignored
    issue(m, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32, fpnorm_pkg::rm_rne,
          7'b1010000, 32'h7fc00000, 5'b10000);                       // Signaling NaN
    issue(m, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32, fpnorm_pkg::rm_rne,
          7'b0100000, 32'h7fc00000, 5'b00000);                       // Quiet NaN in b
    issue(m, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32, fpnorm_pkg::rm_rne,
          7'b0001100, 32'h7fc00000, 5'b10000);                       // Inf/Inf
    issue(m, 127, 1'b1, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32, fpnorm_pkg::rm_rne,
          7'b0000100, 32'h80000000, 5'b00100);                       // x/Inf, zero with OF
    drain();
  endtask

  // Random normals cycling through all five modes
  task automatic test_normal(input logic half);
    logic [31:0]     r, q;
    logic [27:0]     m;
    logic [32:0]     x;
    fpnorm_pkg::rm_e mode;
    int              e, i;
    for (i = 0; i < 5 * n_rand; i++)
    begin
      r    = $random(seed);
      q    = $random(seed);
      mode = fpnorm_pkg::rm_e'(3'(i % 5));
      m    = half ? {1'b1, r[26:4], 4'h0} : {1'b1, r[26:0]};
      e    = half ? 5 + int'(q[3:0]) : 64 + int'(q[6:0]);    // Well inside the range
      x    = expect_normal(m, e, r[31], mode, half);
      issue(m, e, r[31], fpnorm_pkg::op_div,
            half ? fpnorm_pkg::fmt_fp16 : fpnorm_pkg::fmt_fp32, mode, 7'b0,
            x[31:0], {4'b0000, x[32]});
    end
    drain();
  endtask

  // All-ones fraction rounds into the next binade
  task automatic test_carry();
    issue({1'b1, 23'h7fffff, 4'h8}, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rne, 7'b0, 32'h40000000, 5'b00001);   // Tie on odd LSB
    issue({1'b1, 23'h7fffff, 4'h1}, 100, 1'b1, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rdn, 7'b0, 32'hb2800000, 5'b00001);   // Negative, toward -inf
    drain();
  endtask

  // Exact ties on an even LSB in both nearest modes
  task automatic test_ties();
    issue({1'b1, 23'h7ffffe, 4'h8}, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rne, 7'b0, 32'h3ffffffe, 5'b00001);   // Even LSB kept
    issue({1'b1, 23'h7ffffe, 4'h8}, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rmm, 7'b0, 32'h3fffffff, 5'b00001);   // Away from zero
    drain();
  endtask

  // Denormals by right shift, then exponent overflow
  task automatic test_range();
    int          shifts[3] = '{3, 11, 21};
    logic [31:0] r;
    logic [27:0] m, lost, shifted;
    int          i;
    for (i = 0; i < 3; i++)
    begin
      r       = $random(seed);
      m       = {1'b1, r[26:0]};
      shifted = m >> shifts[i];
      lost    = m & ((28'd1 << (shifts[i] + 4)) - 28'd1);  // Below the denormal LSB
      issue(m, 1 - shifts[i], r[31], fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
            fpnorm_pkg::rm_rtz, 7'b0, {r[31], 8'h00, shifted[26:4]}, {4'b0001, |lost});
    end
    issue(28'h8000000, 300, 1'b1, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rne, 7'b0, 32'hff800000, 5'b00100);  // Past 255
    drain();
  endtask

  // Mixed formats and cases on consecutive cycles
  task automatic test_back_to_back();
    issue(28'h8000000, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rne, 7'b0000011, 32'h7fc00000, 5'b11000);
    issue(28'hc000000, 15, 1'b1, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp16,
          fpnorm_pkg::rm_rne, 7'b0, 32'hffffbe00, 5'b00000);   // -1.5 half
    issue(28'h8000000, 127, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rtz, 7'b0, 32'h3f800000, 5'b00000);   // 1.0
    issue(28'h8000000, 300, 1'b0, fpnorm_pkg::op_div, fpnorm_pkg::fmt_fp32,
          fpnorm_pkg::rm_rne, 7'b0, 32'h7f800000, 5'b00100);
    drain();
  endtask

  initial
  begin
    rst      = 1'b1;
    in_valid = 1'b0;
    mant_in  = '0;
    exp_in   = '0;
    sign_in  = 1'b0;
    op       = fpnorm_pkg::op_div;
    fmt      = fpnorm_pkg::fmt_fp32;
    rm       = fpnorm_pkg::rm_rne;
    {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    test_special();
    test_normal(1'b0);
    test_carry();
    test_ties();
    test_range();
    test_normal(1'b1);
    test_back_to_back();
    errors += fpnorm_top_i.fpnorm_props_i.assert_fails;
    if (checks != issued)
    begin
      $display("Error: %0d operations issued but %0d results checked", issued, checks);
      errors++;
    end
    $display("Results checked: %0d of %0d, errors: %0d", checks, issued, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Three cycles per operation plus reset and drain margin
  initial
  begin : watchdog
    int planned_ops;
    planned_ops = 7 + 10 * n_rand + 2 + 2 + 4 + 4;
    repeat (planned_ops * 3 + 60) @(posedge clk);
    $display("Error: watchdog expired at cycle %0d, run did not finish", cycle);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== tb/fpnorm_props.sv ====
/* Concurrent checks on pipeline latency, reset and the NV/DZ pair.
   Bound into the top level at the end of this file. */
`timescale 1ns/100ps

module fpnorm_props
(
  input logic                            clk,
  input logic                            rst,
  input logic                            in_valid,
  input fpnorm_pkg::op_e                 op,
  input logic                            inf_a,
  input logic                            inf_b,
  input logic                            zero_a,
  input logic                            zero_b,
  input logic                            nan_a,
  input logic                            nan_b,
  input logic                            out_valid,
  input logic [fpnorm_pkg::fflags_w-1:0] fflags
);

  int   assert_fails = 0;  // Failure count
  logic zero_div;          // Operation takes the 0/0 branch

  assign zero_div = in_valid && (op == fpnorm_pkg::op_div) && zero_a && zero_b &&
                    !(nan_a || nan_b || inf_a || inf_b);

  latency_check: assert property (@(posedge clk) disable iff (rst)
                                  out_valid == $past(in_valid, 2))
    else
    begin
      assert_fails++;
      $error("out_valid does not follow in_valid by two cycles");
    end

  reset_check: assert property (@(posedge clk) rst |=> !out_valid)
    else
    begin
      assert_fails++;
      $error("out_valid high after a reset cycle");
    end

  // NV and DZ together only for 0/0
  flag_check: assert property (@(posedge clk) disable iff (rst)
                               (out_valid && fflags[4] && fflags[3]) |-> $past(zero_div, 2))
    else
    begin
      assert_fails++;
      $error("NV and DZ both set without a 0/0 operation");
    end

endmodule

bind fpnorm_top fpnorm_props fpnorm_props_i
(
  .clk, .rst, .in_valid, .op, .inf_a, .inf_b, .zero_a, .zero_b, .nan_a, .nan_b,
  .out_valid, .fflags
);

// ==== tb/tb_clock.sv ====
/* Free-running testbench clock with a 4 ns period */
`timescale 1ns/100ps

module tb_clock
(
  output logic clk
);

  initial
    clk = 1'b0;

  always
    #2 clk = ~clk;  // Half period

endmodule

// ==== hdl/fpnorm_top.sv ====
/* Two-stage normalize-and-round unit for the div/sqrt back end.
   Result and flags appear two cycles after in_valid; one new operation per cycle. */
`timescale 1ns/100ps

module fpnorm_top
(
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  in_valid,
  input  logic [fpnorm_pkg::mant_in_w-1:0]                      mant_in,
  input  logic signed [fpnorm_pkg::exp_in_w-1:0]                exp_in,
  input  logic                                                  sign_in,
  input  fpnorm_pkg::op_e                                       op,
  input  fpnorm_pkg::fmt_e                                      fmt,
  input  fpnorm_pkg::rm_e                                       rm,
  input  logic                                                  inf_a,
  input  logic                                                  inf_b,
  input  logic                                                  zero_a,
  input  logic                                                  zero_b,
  input  logic                                                  nan_a,
  input  logic                                                  nan_b,
  input  logic                                                  snan,
  output logic                                                  out_valid,
  output logic [fpnorm_pkg::exp_w_fp32+fpnorm_pkg::mant_w_fp32:0] result,
  output logic [fpnorm_pkg::fflags_w-1:0]                       fflags
);

  // Stage 1 -> stage 2
  logic                                  n_valid;
  logic                                  n_sign;
  fpnorm_pkg::fmt_e                      n_fmt;
  fpnorm_pkg::rm_e                       n_rm;
  logic [fpnorm_pkg::mant_w_fp32:0]      n_mant;        // Hidden + fraction
  logic [fpnorm_pkg::exp_w_fp32-1:0]     n_exp;
  logic [fpnorm_pkg::mant_in_w-1:0]      n_round_bits;  // Below FP32 LSB
  logic                                  n_special;
  logic                                  n_nv, n_dz, n_of, n_uf;

  fp_normalize fp_normalize_i
  (
    .clk, .rst, .in_valid,
    .mant_in, .exp_in, .sign_in, .op, .fmt, .rm,
    .inf_a, .inf_b, .zero_a, .zero_b, .nan_a, .nan_b, .snan,
    .n_valid, .n_sign, .n_fmt, .n_rm, .n_mant, .n_exp, .n_round_bits,
    .n_special, .n_nv, .n_dz, .n_of, .n_uf
  );

  fp_round fp_round_i
  (
    .clk, .rst,
    .n_valid, .n_sign, .n_fmt, .n_rm, .n_mant, .n_exp, .n_round_bits,
    .n_special, .n_nv, .n_dz, .n_of, .n_uf,
    .out_valid, .result, .fflags
  );

endmodule

// ==== hdl/fp_round.sv ====
/* Stage 2: rounding, carry renormalization, packing and NaN boxing.
   Output register holds result and flags; NX is decided here only. */
`timescale 1ns/100ps

module fp_round
(
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  n_valid,
  input  logic                                                  n_sign,
  input  fpnorm_pkg::fmt_e                                      n_fmt,
  input  fpnorm_pkg::rm_e                                       n_rm,
  input  logic [fpnorm_pkg::mant_w_fp32:0]                      n_mant,
  input  logic [fpnorm_pkg::exp_w_fp32-1:0]                     n_exp,
  input  logic [fpnorm_pkg::mant_in_w-1:0]                      n_round_bits,
  input  logic                                                  n_special,
  input  logic                                                  n_nv,
  input  logic                                                  n_dz,
  input  logic                                                  n_of,
  input  logic                                                  n_uf,
  output logic                                                  out_valid,
  output logic [fpnorm_pkg::exp_w_fp32+fpnorm_pkg::mant_w_fp32:0] result,
  output logic [fpnorm_pkg::fflags_w-1:0]                       fflags
);

  logic                                  is_fp16;
  logic [fpnorm_pkg::mant_w_fp32:0]      mant_upper;   // Bits below format LSB cleared
  logic [fpnorm_pkg::mant_w_fp32+1:0]    inc_vec;      // One at format LSB
  logic [fpnorm_pkg::mant_w_fp32+1:0]    mant_sum;
  logic                                  guard_bit, round_bit, sticky_bit, lsb_bit;
  logic                                  inexact, round_up, renorm;
  logic [fpnorm_pkg::mant_w_fp32-1:0]    mant_res;
  logic [fpnorm_pkg::exp_w_fp32-1:0]     exp_res;

  assign is_fp16 = (n_fmt == fpnorm_pkg::fmt_fp16);

  //////////////////////////////
  // Round position by format
  //////////////////////////////
  always_comb
  begin
    if (is_fp16)                            // LSB at bit 13
    begin
      mant_upper = {n_mant[23:13], 13'b0};
      lsb_bit    = n_mant[13];
      guard_bit  = n_mant[12];
      round_bit  = n_mant[11];
      sticky_bit = |n_mant[10:0];
      inc_vec    = 25'd1 << (fpnorm_pkg::mant_w_fp32 - fpnorm_pkg::mant_w_fp16);
    end
    else
    begin
      mant_upper = n_mant;
      lsb_bit    = n_mant[0];
      guard_bit  = n_round_bits[27];
      round_bit  = n_round_bits[26];
      sticky_bit = |n_round_bits[25:0];
      inc_vec    = 25'd1;
    end
  end

  assign inexact = (guard_bit | round_bit | sticky_bit) & ~n_special;

  // Round-up decision
  always_comb
  begin
    round_up = 1'b0;
    case (n_rm)
      fpnorm_pkg::rm_rne: round_up = guard_bit & (round_bit | sticky_bit | lsb_bit);
      fpnorm_pkg::rm_rtz: round_up = 1'b0;
      fpnorm_pkg::rm_rdn: round_up = inexact & n_sign;
      fpnorm_pkg::rm_rup: round_up = inexact & ~n_sign;
      fpnorm_pkg::rm_rmm: round_up = guard_bit;     // Tie goes away from zero
      default:            round_up = 1'b0;
    endcase
    if (n_special)
      round_up = 1'b0;                              // Fixed results are exact
  end

  assign mant_sum = {1'b0, mant_upper} + (round_up ? inc_vec : '0);
  assign renorm   = mant_sum[fpnorm_pkg::mant_w_fp32+1];  // Carry out of 1.111

  // Shift right one on carry, bump the exponent
  assign mant_res = renorm ? mant_sum[fpnorm_pkg::mant_w_fp32:1]
                  : mant_sum[fpnorm_pkg::mant_w_fp32-1:0];
  assign exp_res  = n_exp + {{(fpnorm_pkg::exp_w_fp32-1){1'b0}}, renorm};

  //////////////////////////////
  // Output register
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= n_valid;
  end

  always_ff @(posedge clk)
  begin
    if (n_valid)
    begin
      if (is_fp16)                          // NaN-boxed half
        result <= {16'hffff, n_sign, exp_res[fpnorm_pkg::exp_w_fp16-1:0],
                   mant_res[22:13]};
      else
        result <= {n_sign, exp_res, mant_res};
      fflags <= {n_nv, n_dz, n_of, n_uf, inexact};  // {NV,DZ,OF,UF,NX}
    end
  end

endmodule

// ==== hdl/fp_normalize.sv ====
/* Stage 1: special-case resolution, normalization and denormal right shift.
   Registers the normalized mantissa, exponent and bits below the FP32 LSB. */
`timescale 1ns/100ps

module fp_normalize
(
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    in_valid,
  input  logic [fpnorm_pkg::mant_in_w-1:0]        mant_in,   // [27] hidden, [3:0] guard
  input  logic signed [fpnorm_pkg::exp_in_w-1:0]  exp_in,
  input  logic                                    sign_in,
  input  fpnorm_pkg::op_e                         op,
  input  fpnorm_pkg::fmt_e                        fmt,
  input  fpnorm_pkg::rm_e                         rm,
  input  logic                                    inf_a,
  input  logic                                    inf_b,
  input  logic                                    zero_a,
  input  logic                                    zero_b,
  input  logic                                    nan_a,
  input  logic                                    nan_b,
  input  logic                                    snan,
  output logic                                    n_valid,
  output logic                                    n_sign,
  output fpnorm_pkg::fmt_e                        n_fmt,
  output fpnorm_pkg::rm_e                         n_rm,
  output logic [fpnorm_pkg::mant_w_fp32:0]        n_mant,
  output logic [fpnorm_pkg::exp_w_fp32-1:0]       n_exp,
  output logic [fpnorm_pkg::mant_in_w-1:0]        n_round_bits,
  output logic                                    n_special,
  output logic                                    n_nv,
  output logic                                    n_dz,
  output logic                                    n_of,
  output logic                                    n_uf
);

  logic is_div, is_sqrt;
  logic exp_ovf, exp_max;

  // Denormal shift, only meaningful for negative exponents
  logic [fpnorm_pkg::exp_in_w-1:0]     num_rs;
  logic [fpnorm_pkg::mant_w_fp32:0]    rs_mant;
  logic [fpnorm_pkg::mant_in_w-1:0]    rs_round;
  logic [fpnorm_pkg::exp_in_w-1:0]     exp_m1;

  // Next-state values
  logic                                sign_d, special_d, nv_d, dz_d, of_d, uf_d;
  logic [fpnorm_pkg::mant_w_fp32:0]    mant_d;
  logic [fpnorm_pkg::exp_w_fp32-1:0]   exp_d;
  logic [fpnorm_pkg::mant_in_w-1:0]    round_d;

  assign is_div  = (op == fpnorm_pkg::op_div);
  assign is_sqrt = (op == fpnorm_pkg::op_sqrt);

  assign num_rs = ~exp_in + 2'd2;  // 1 - exp
  assign {rs_mant, rs_round} = {mant_in, {(fpnorm_pkg::mant_w_fp32+1){1'b0}}} >> num_rs;
  assign exp_m1 = exp_in - 1'b1;  // For 0.1xxx inputs

  // Exponent past the format range
  assign exp_ovf = (fmt == fpnorm_pkg::fmt_fp32) ? exp_in[fpnorm_pkg::exp_w_fp32]
                 : |exp_in[fpnorm_pkg::exp_in_w-2:fpnorm_pkg::exp_w_fp16];
  assign exp_max = (fmt == fpnorm_pkg::fmt_fp32) ? &exp_in[fpnorm_pkg::exp_w_fp32-1:0]
                 : &exp_in[fpnorm_pkg::exp_w_fp16-1:0];

  //////////////////////////////
  // Special-case chain
  //////////////////////////////
  always_comb
  begin
    sign_d    = sign_in;
    special_d = 1'b1;       // Most branches give a fixed result
    nv_d      = 1'b0;
    dz_d      = 1'b0;
    of_d      = 1'b0;
    uf_d      = 1'b0;
    mant_d    = '0;
    exp_d     = '0;
    round_d   = '0;
    if (nan_a || nan_b)                     // NaN in, NaN out
    begin
      mant_d = {1'b0, fpnorm_pkg::mant_nan_fp32};
      exp_d  = '1;
      sign_d = 1'b0;
      nv_d   = snan;
    end
    else if (inf_a)
    begin
      exp_d = '1;
      if ((is_div && inf_b) || (is_sqrt && sign_in))  // Inf/Inf, sqrt(-Inf)
      begin
        mant_d = {1'b0, fpnorm_pkg::mant_nan_fp32};
        sign_d = 1'b0;
        nv_d   = 1'b1;
      end
      else
        of_d = 1'b1;                        // Signed Inf
    end
    else if (is_div && inf_b)
      of_d = 1'b1;                          // x/Inf, zero with OF as in the reference
    else if (zero_a)
    begin
      if (is_div && zero_b)                 // 0/0
      begin
        mant_d = {1'b0, fpnorm_pkg::mant_nan_fp32};
        exp_d  = '1;
        sign_d = 1'b0;
        nv_d   = 1'b1;
        dz_d   = 1'b1;
      end
    end
    else if (is_div && zero_b)              // x/0 -> signed Inf
    begin
      exp_d = '1;
      dz_d  = 1'b1;
    end
    else if (is_sqrt && sign_in)            // sqrt(-a)
    begin
      mant_d = {1'b0, fpnorm_pkg::mant_nan_fp32};
      exp_d  = '1;
      sign_d = 1'b0;
      nv_d   = 1'b1;
    end
    else if (exp_in[fpnorm_pkg::exp_w_fp32:0] == '0)
    begin
      if (mant_in != '0)                    // Denormal, one bit right
      begin
        special_d = 1'b0;
        uf_d      = 1'b1;
        mant_d    = {1'b0, mant_in[27:5]};
        round_d   = {mant_in[4:0], 23'b0};
      end
    end
    else if ((exp_in[fpnorm_pkg::exp_w_fp32:0] == {1'b0, fpnorm_pkg::exp_one_fp32}) &&
             !mant_in[27])
    begin
      special_d = 1'b0;                     // 0.1xxx at exp 1 lands on denormal
      uf_d      = 1'b1;
      mant_d    = mant_in[27:4];
      round_d   = {mant_in[3:0], 24'b0};
    end
    else if (exp_in[fpnorm_pkg::exp_in_w-1])  // Negative exponent
    begin
      special_d = 1'b0;
      uf_d      = 1'b1;
      mant_d    = rs_mant;
      round_d   = rs_round;
    end
    else if (exp_ovf)
    begin
      exp_d = '1;
      of_d  = 1'b1;
    end
    else if (exp_max && mant_in[27])         // 1.xxx at max exp overflows
    begin
      exp_d = '1;
      of_d  = 1'b1;
    end
    else if (mant_in[27])                    // 1.xxx
    begin
      special_d = 1'b0;
      mant_d    = mant_in[27:4];
      exp_d     = exp_in[fpnorm_pkg::exp_w_fp32-1:0];
      round_d   = {mant_in[3:0], 24'b0};
    end
    else                                     // 0.1xxx, also at max exp
    begin
      special_d = 1'b0;
      mant_d    = mant_in[26:3];
      exp_d     = exp_m1[fpnorm_pkg::exp_w_fp32-1:0];
      round_d   = {mant_in[2:0], 25'b0};
    end
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
      n_valid <= 1'b0;
    else
      n_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      n_sign       <= sign_d;
      n_fmt        <= fmt;
      n_rm         <= rm;        // Kept aligned with its data
      n_mant       <= mant_d;
      n_exp        <= exp_d;
      n_round_bits <= round_d;
      n_special    <= special_d;
      {n_nv, n_dz, n_of, n_uf} <= {nv_d, dz_d, of_d, uf_d};
    end
  end

endmodule

// ==== hdl/fpnorm_pkg.sv ====
/* Shared widths, constants and enums for the divide/sqrt normalize-and-round pipeline.
   Referenced by scoped name from the RTL and the testbench. */

package fpnorm_pkg;

  //////////////////////////////
  // Format field widths
  //////////////////////////////
  localparam int exp_w_fp32  = 8;   // FP32 exponent field
  localparam int exp_w_fp16  = 5;   // FP16 exponent field
  localparam int mant_w_fp32 = 23;  // FP32 fraction field
  localparam int mant_w_fp16 = 10;  // FP16 fraction field

  // Datapath input sizing, always FP32 wide
  localparam int mant_in_w = mant_w_fp32 + 5;  // Hidden bit + fraction + 4 guard bits
  localparam int exp_in_w  = exp_w_fp32 + 2;   // Signed, one extra bit for overflow

  //////////////////////////////
  // Special constants
  //////////////////////////////
  // Quiet NaN fraction, MSB set
  localparam logic [mant_w_fp32-1:0] mant_nan_fp32 = {1'b1, {(mant_w_fp32-1){1'b0}}};

  localparam logic [exp_w_fp32-1:0] exp_one_fp32 = 1;  // Smallest normal exponent

  // Flag vector {NV, DZ, OF, UF, NX}, NV at the MSB
  localparam int fflags_w = 5;

  //////////////////////////////
  // Enums
  //////////////////////////////
  typedef enum logic
  {
    fmt_fp32,  // Single precision
    fmt_fp16   // Half precision, NaN-boxed in 32 bits
  } fmt_e;

  typedef enum logic
  {
    op_div,   // a / b
    op_sqrt   // sqrt(a), b flags ignored
  } op_e;

  // Rounding modes, RISC-V frm encoding
  typedef enum logic [2:0]
  {
    rm_rne = 3'd0,  // Nearest, ties to even
    rm_rtz = 3'd1,  // Toward zero
    rm_rdn = 3'd2,  // Toward -inf
    rm_rup = 3'd3,  // Toward +inf
    rm_rmm = 3'd4   // Nearest, ties away
  } rm_e;

endpackage
